/* sim.f */
common/lab4d_pkg.sv
lab4d_serial/lab4d_serial_shifter.sv
lab4d_ramp/lab4d_wilkinson_ramp.sv
hw/lab4d_regs.sv
hw/lab4d_controller.sv
test/tb_lab4d_controller.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if the pass message appears.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_lab4d_controller \
	&& ./obj_dir/Vtb_lab4d_controller | tee /dev/stderr | grep -q "All tests passed!" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* test/tb_lab4d_controller.sv */
`timescale 1ns/1ps

module tb_lab4d_controller;

	localparam int ack_limit = 20;
	localparam int poll_limit = 1000;

	logic clk_i;
	logic rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	logic [3:0] wb_sel_i;
	logic [6:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic wb_ack_o;
	logic wb_err_o;
	logic wb_rty_o;
	logic [11:0] regclr_o;
	logic [11:0] ramp_o;
	logic [11:0] wclk_p_o;
	logic [11:0] wclk_n_o;
	logic [11:0] sin_o;
	logic [11:0] sclk_o;
	logic [11:0] pclk_o;

	int errors;
	int checks;
	logic [31:0] lfsr_state;

	// monitor state set up by the stimulus before each load or ramp
	int watch_chip;
	logic broadcast;
	int cur_prescale;
	logic [23:0] rebuilt;
	int sclk_rises;
	int pclk_pulses;
	int high_len;
	int wclk_edges;
	logic sclk_last;
	logic pclk_last;
	logic wclk_last;

	lab4d_controller u_lab4d_controller (.*);

	always #50 clk_i = ~clk_i;

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout: no response from the DUT while waiting for %s", what);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	endtask

	task automatic bus_access(input logic we, input int idx, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i <= we;
		wb_sel_i <= 4'hf;
		wb_adr_i <= 7'(idx * 4);
		wb_dat_i <= wdata;
		do begin
			@(negedge clk_i);
			waited++;
			if (waited > ack_limit) give_up("the Wishbone ack");
		end while (!wb_ack_o);
		rdata = wb_dat_o;
		@(posedge clk_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i <= 1'b0;
	endtask

	task automatic bus_write(input int idx, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, idx, data, unused);
	endtask

	task automatic bus_read(input int idx, output logic [31:0] data);
		bus_access(1'b0, idx, 32'd0, data);
	endtask

	task automatic wait_bit_clear(input int idx, input int pos, input string what);
		logic [31:0] word;
		int polls;
		polls = 0;
		do begin
			bus_read(idx, word);
			polls++;
			if (polls > poll_limit) give_up(what);
		end while (word[pos]);
	endtask

	task automatic serial_load(input logic [3:0] sel, input logic [23:0] data, input int pre);
		logic [31:0] word;
		bus_write(lab4d_pkg::reg_shift_prescale, pre);
		cur_prescale = pre;
		broadcast = sel >= 4'd12;
		watch_chip = broadcast ? 0 : int'(sel);
		rebuilt = '0;
		sclk_rises = 0;
		pclk_pulses = 0;
		bus_write(lab4d_pkg::reg_serial, {1'b1, 3'b000, sel, data});
		bus_read(lab4d_pkg::reg_serial, word);
		check_value("serial command readback", word & 32'h0fff_ffff, {4'h0, sel, data});
		wait_bit_clear(lab4d_pkg::reg_serial, 31, "the serial busy bit to clear");
		check_value("word rebuilt from SIN", rebuilt, data);
		check_value("SCLK rising edges", sclk_rises, 24);
		check_value("PCLK pulses", pclk_pulses, 1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// bus and pin monitors
	//////////////////////////////////////////////////////////////////////

	ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i) wb_ack_o |=> !wb_ack_o)
		else begin
			errors++;
			$display("** Error at %0t ns: ack held for more than one cycle", $time);
		end

	no_err_rty: assert property (@(posedge clk_i) disable iff (rst_i) !(wb_err_o || wb_rty_o))
		else begin
			errors++;
			$display("** Error at %0t ns: err or rty asserted", $time);
		end

	always @(negedge clk_i) begin : pin_monitor
		logic [11:0] mask;
		logic [11:0] stray;
		logic [11:0] wclk_inv;
		if (!rst_i) begin
			mask = broadcast ? 12'hfff : (12'd1 << watch_chip);
			stray = (sin_o | sclk_o | pclk_o) & ~mask;
			check_value("serial lines on idle chips", stray, 0);
			if (broadcast) begin
				check_value("broadcast SIN", sin_o, {12{sin_o[0]}});
				check_value("broadcast SCLK", sclk_o, {12{sclk_o[0]}});
				check_value("broadcast PCLK", pclk_o, {12{pclk_o[0]}});
			end
			if (sclk_o[watch_chip] && !sclk_last) begin
				rebuilt = {rebuilt[22:0], sin_o[watch_chip]};
				sclk_rises++;
			end
			if (sclk_o[watch_chip]) begin
				high_len++;
			end else if (sclk_last) begin
				check_value("SCLK high phase length", high_len, cur_prescale + 1);
				high_len = 0;
			end
			if (pclk_o[watch_chip] && !pclk_last) pclk_pulses++;
			// ramp side with all twelve chips driven alike
			check_value("RAMP across chips", ramp_o, {12{ramp_o[0]}});
			check_value("WCLK_P across chips", wclk_p_o, {12{wclk_p_o[0]}});
			if (wclk_p_o[0] && !wclk_last) begin
				wclk_edges++;
				check_value("RAMP at WCLK_P edge", ramp_o, 12'hfff);
			end
			wclk_inv = ~wclk_p_o;
			if (ramp_o[0] && wclk_edges > 0) check_value("WCLK_N", wclk_n_o, wclk_inv);
			sclk_last = sclk_o[watch_chip];
			pclk_last = pclk_o[watch_chip];
			wclk_last = wclk_p_o[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] word;
		logic [31:0] rd;
		logic [31:0] v;
		int dly;
		int stop;
		errors = 0;
		checks = 0;
		lfsr_state = 32'h417087bc;
		clk_i = 1'b0;
		rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_sel_i = 4'h0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		watch_chip = 0;
		broadcast = 1'b0;
		cur_prescale = 0;
		rebuilt = '0;
		sclk_rises = 0;
		pclk_pulses = 0;
		high_len = 0;
		wclk_edges = 0;
		sclk_last = 1'b0;
		pclk_last = 1'b0;
		wclk_last = 1'b0;
		repeat (10) @(posedge clk_i);
		rst_i <= 1'b0;

		// reset values
		bus_read(lab4d_pkg::reg_control, rd);
		check_value("control after reset", rd, 0);
		bus_read(lab4d_pkg::reg_shift_prescale, rd);
		check_value("prescale after reset", rd, 0);
		bus_read(lab4d_pkg::reg_ramp_delay, rd);
		check_value("ramp delay after reset", rd, 0);
		bus_read(lab4d_pkg::reg_wclk_stop, rd);
		check_value("stop count after reset", rd, 4096);
		bus_read(lab4d_pkg::reg_serial, rd);
		check_value("serial after reset", rd, 0);
		check_value("REGCLR and RAMP after reset", {regclr_o, ramp_o}, 0);
		check_value("WCLK after reset", {wclk_p_o, wclk_n_o}, 0);
		check_value("SIN and SCLK after reset", {sin_o, sclk_o}, 0);
		check_value("PCLK after reset", pclk_o, 0);

		// register fields
		rand_bits(32, word);
		bus_write(lab4d_pkg::reg_shift_prescale, word);
		bus_read(lab4d_pkg::reg_shift_prescale, rd);
		check_value("prescale readback", rd, word & 32'h0000_00ff);
		rand_bits(32, word);
		bus_write(lab4d_pkg::reg_ramp_delay, word);
		bus_read(lab4d_pkg::reg_ramp_delay, rd);
		check_value("ramp delay readback", rd, word & 32'h0000_ffff);
		rand_bits(32, word);
		bus_write(lab4d_pkg::reg_wclk_stop, word);
		bus_read(lab4d_pkg::reg_wclk_stop, rd);
		check_value("stop count readback", rd, word & 32'h0000_ffff);
		rand_bits(32, word);
		word[3] = 1'b0;
		bus_write(lab4d_pkg::reg_control, word);
		bus_read(lab4d_pkg::reg_control, rd);
		check_value("control readback", rd, word & 32'h0fff_0002);
		check_value("REGCLR", regclr_o, word[27:16]);
		rand_bits(32, word);
		bus_write(9, word);
		bus_read(9, rd);
		check_value("unmapped word 9", rd, 0);
		bus_write(lab4d_pkg::reg_control, 32'd0);

		// loads to single chips and then a broadcast
		for (int n = 0; n < 3; n++) begin
			rand_bits(4, v);
			word[3:0] = 4'(v % 12);
			rand_bits(24, rd);
			rand_bits(3, v);
			serial_load(word[3:0], rd[23:0], int'(v));
		end
		rand_bits(24, rd);
		rand_bits(3, v);
		serial_load(4'd15, rd[23:0], int'(v));

		//////////////////////////////////////////////////////////////////////
		// ramp and Wilkinson clock
		//////////////////////////////////////////////////////////////////////

		rand_bits(3, v);
		dly = int'(v) + 2;
		rand_bits(4, v);
		stop = int'(v) + 4;
		bus_write(lab4d_pkg::reg_ramp_delay, dly);
		bus_write(lab4d_pkg::reg_wclk_stop, stop);
		wclk_edges = 0;
		bus_write(lab4d_pkg::reg_control, 32'h8);
		bus_read(lab4d_pkg::reg_control, rd);
		// go bit reads back as zero and busy is set
		check_value("control while ramp runs", rd, 32'h0000_0010);
		// restart attempt while busy
		bus_write(lab4d_pkg::reg_control, 32'h8);
		wait_bit_clear(lab4d_pkg::reg_control, 4, "the ramp busy bit to clear");
		check_value("WCLK_P rising edges", wclk_edges, stop);
		check_value("RAMP after sequence", ramp_o, 0);
		check_value("WCLK after sequence", {wclk_p_o, wclk_n_o}, 0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* hw/lab4d_controller.sv */
`timescale 1ns/1ps

module lab4d_controller (
	input  logic clk_i,
	input  logic rst_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [lab4d_pkg::wb_dat_width/8-1:0] wb_sel_i,
	input  logic [lab4d_pkg::wb_adr_width-1:0] wb_adr_i,
	input  logic [lab4d_pkg::wb_dat_width-1:0] wb_dat_i,
	output logic [lab4d_pkg::wb_dat_width-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	output logic wb_rty_o,
	output logic [lab4d_pkg::num_chips-1:0] regclr_o,
	output logic [lab4d_pkg::num_chips-1:0] ramp_o,
	output logic [lab4d_pkg::num_chips-1:0] wclk_p_o,
	output logic [lab4d_pkg::num_chips-1:0] wclk_n_o,
	output logic [lab4d_pkg::num_chips-1:0] sin_o,
	output logic [lab4d_pkg::num_chips-1:0] sclk_o,
	output logic [lab4d_pkg::num_chips-1:0] pclk_o
);

	lab4d_pkg::serial_cmd_t serial_cmd;
	lab4d_pkg::ramp_cfg_t ramp_cfg;
	lab4d_pkg::lab4_serial_t serial_pins;
	logic serial_go;
	logic serial_busy;
	logic ramp_go;
	logic ramp_busy;
	logic [7:0] shift_prescale;

	lab4d_regs u_regs (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.wb_err_o(wb_err_o),
		.wb_rty_o(wb_rty_o),
		.serial_busy_i(serial_busy),
		.ramp_busy_i(ramp_busy),
		.serial_cmd_o(serial_cmd),
		.serial_go_o(serial_go),
		.shift_prescale_o(shift_prescale),
		.ramp_cfg_o(ramp_cfg),
		.ramp_go_o(ramp_go),
		.regclr_o(regclr_o)
	);

	lab4d_serial_shifter u_shifter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.go_i(serial_go),
		.cmd_i(serial_cmd),
		.prescale_i(shift_prescale),
		.busy_o(serial_busy),
		.pins_o(serial_pins)
	);

	lab4d_wilkinson_ramp u_ramp (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.go_i(ramp_go),
		.cfg_i(ramp_cfg),
		.busy_o(ramp_busy),
		.ramp_o(ramp_o),
		.wclk_p_o(wclk_p_o),
		.wclk_n_o(wclk_n_o)
	);

	// chip serial buses out to the pins
	assign sin_o = serial_pins.sin;
	assign sclk_o = serial_pins.sclk;
	assign pclk_o = serial_pins.pclk;

endmodule

/* hw/lab4d_regs.sv */
`timescale 1ns/1ps

module lab4d_regs (
	input  logic clk_i,
	input  logic rst_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [lab4d_pkg::wb_dat_width/8-1:0] wb_sel_i,
	input  logic [lab4d_pkg::wb_adr_width-1:0] wb_adr_i,
	input  logic [lab4d_pkg::wb_dat_width-1:0] wb_dat_i,
	output logic [lab4d_pkg::wb_dat_width-1:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o,
	output logic wb_rty_o,
	input  logic serial_busy_i,
	input  logic ramp_busy_i,
	output lab4d_pkg::serial_cmd_t serial_cmd_o,
	output logic serial_go_o,
	output logic [7:0] shift_prescale_o,
	output lab4d_pkg::ramp_cfg_t ramp_cfg_o,
	output logic ramp_go_o,
	output logic [lab4d_pkg::num_chips-1:0] regclr_o
);

	logic ack_q;
	logic wr_en;
	logic [lab4d_pkg::wb_adr_width-3:0] word_idx;
	logic [lab4d_pkg::wb_dat_width-1:0] byte_mask;
	logic [lab4d_pkg::wb_dat_width-1:0] wr_word;
	logic [lab4d_pkg::wb_dat_width-1:0] rd_word;

	logic runmode_req;
	logic [lab4d_pkg::num_chips-1:0] regclear;
	logic [7:0] shift_prescale;
	logic [15:0] ramp_delay;
	logic [15:0] wclk_stop;
	lab4d_pkg::serial_cmd_t serial_cmd;
	logic serial_go_q;
	logic ramp_go_q;

	//////////////////////////////////////////////////////////////////////
	// bus decode
	//////////////////////////////////////////////////////////////////////

	assign word_idx = wb_adr_i[lab4d_pkg::wb_adr_width-1:2];

	// one ack per request and the write lands on the ack edge
	assign wr_en = wb_cyc_i && wb_stb_i && wb_we_i && !ack_q;

	always_comb begin
		for (int i = 0; i < lab4d_pkg::wb_dat_width / 8; i++) begin
			byte_mask[i*8 +: 8] = {8{wb_sel_i[i]}};
		end
	end

	// unselected byte lanes keep their old contents
	assign wr_word = (rd_word & ~byte_mask) | (wb_dat_i & byte_mask);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_q <= 1'b0;
			serial_go_q <= 1'b0;
			ramp_go_q <= 1'b0;
			runmode_req <= 1'b0;
			regclear <= '0;
			shift_prescale <= lab4d_pkg::shift_prescale_default;
			ramp_delay <= lab4d_pkg::ramp_delay_default;
			wclk_stop <= lab4d_pkg::wclk_stop_default;
			serial_cmd <= '0;
		end else begin
			ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
			serial_go_q <= 1'b0;
			ramp_go_q <= 1'b0;
			if (wr_en) begin
				case (word_idx)
					lab4d_pkg::reg_control: begin
						runmode_req <= wr_word[lab4d_pkg::ctrl_runmode_bit];
						regclear <= wr_word[lab4d_pkg::ctrl_regclr_lsb +: lab4d_pkg::num_chips];
						// ramp start is a write-one strobe
						ramp_go_q <= wb_dat_i[lab4d_pkg::ctrl_ramp_go_bit] && wb_sel_i[0];
					end
					lab4d_pkg::reg_shift_prescale: shift_prescale <= wr_word[7:0];
					lab4d_pkg::reg_ramp_delay: ramp_delay <= wr_word[15:0];
					lab4d_pkg::reg_wclk_stop: wclk_stop <= wr_word[15:0];
					lab4d_pkg::reg_serial: begin
						serial_cmd <= wr_word[$bits(serial_cmd)-1:0];
						serial_go_q <= wb_dat_i[lab4d_pkg::serial_go_bit] && wb_sel_i[3];
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_word = '0;
		case (word_idx)
			lab4d_pkg::reg_control: begin
				rd_word[lab4d_pkg::ctrl_runmode_bit] = runmode_req;
				rd_word[lab4d_pkg::ctrl_ramp_busy_bit] = ramp_busy_i;
				rd_word[lab4d_pkg::ctrl_regclr_lsb +: lab4d_pkg::num_chips] = regclear;
			end
			lab4d_pkg::reg_shift_prescale: rd_word[7:0] = shift_prescale;
			lab4d_pkg::reg_ramp_delay: rd_word[15:0] = ramp_delay;
			lab4d_pkg::reg_wclk_stop: rd_word[15:0] = wclk_stop;
			lab4d_pkg::reg_serial: begin
				rd_word[$bits(serial_cmd)-1:0] = serial_cmd;
				rd_word[lab4d_pkg::serial_go_bit] = serial_busy_i;
			end
			default: ;
		endcase
	end

	assign wb_dat_o = rd_word;
	assign wb_ack_o = ack_q;
	assign wb_err_o = 1'b0;
	assign wb_rty_o = 1'b0;

	assign serial_cmd_o = serial_cmd;
	assign serial_go_o = serial_go_q;
	assign shift_prescale_o = shift_prescale;
	assign ramp_cfg_o.delay = ramp_delay;
	assign ramp_cfg_o.stop_count = wclk_stop;
	assign ramp_go_o = ramp_go_q;
	assign regclr_o = regclear;

endmodule

/* lab4d_ramp/lab4d_wilkinson_ramp.sv */
`timescale 1ns/1ps

module lab4d_wilkinson_ramp (
	input  logic clk_i,
	input  logic rst_i,
	input  logic go_i,
	input  lab4d_pkg::ramp_cfg_t cfg_i,
	output logic busy_o,
	output logic [lab4d_pkg::num_chips-1:0] ramp_o,
	output logic [lab4d_pkg::num_chips-1:0] wclk_p_o,
	output logic [lab4d_pkg::num_chips-1:0] wclk_n_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_delay,
		st_count,
		st_done
	} ramp_state_t;

	ramp_state_t state;
	lab4d_pkg::ramp_cfg_t cfg_q;
	logic [15:0] cnt;
	logic wclk_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= st_idle;
			cnt <= '0;
			wclk_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					cnt <= '0;
					wclk_q <= 1'b0;
					if (go_i) begin
						if (cfg_i.delay != '0) state <= st_delay;
						else if (cfg_i.stop_count != '0) state <= st_count;
						else state <= st_done;
					end
				end
				st_delay: begin
					if (cnt == cfg_q.delay - 1'b1) begin
						cnt <= '0;
						state <= (cfg_q.stop_count != '0) ? st_count : st_done;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_count: begin
					// cnt holds the rising edges so far
					if (wclk_q && cnt == cfg_q.stop_count) begin
						wclk_q <= 1'b0;
						state <= st_done;
					end else begin
						wclk_q <= ~wclk_q;
						if (!wclk_q) cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == st_idle && go_i) cfg_q <= cfg_i;
	end

	assign busy_o = state != st_idle;
	assign ramp_o = {lab4d_pkg::num_chips{state == st_delay || state == st_count}};
	assign wclk_p_o = {lab4d_pkg::num_chips{wclk_q}};
	assign wclk_n_o = {lab4d_pkg::num_chips{state == st_count && !wclk_q}};

endmodule

/* lab4d_serial/lab4d_serial_shifter.sv */
`timescale 1ns/1ps

module lab4d_serial_shifter (
	input  logic clk_i,
	input  logic rst_i,
	input  logic go_i,
	input  lab4d_pkg::serial_cmd_t cmd_i,
	input  logic [7:0] prescale_i,
	output logic busy_o,
	output lab4d_pkg::lab4_serial_t pins_o
);

	logic busy_q;
	logic [7:0] pre_cnt;
	logic [7:0] prescale_q;
	logic [lab4d_pkg::shift_phase_width-1:0] phase;
	logic [lab4d_pkg::serial_width-1:0] shreg;
	logic [3:0] sel_q;
	logic phase_end;
	logic in_bits;
	logic sin_bit;
	logic sclk_bit;
	logic pclk_bit;
	logic [lab4d_pkg::num_chips-1:0] chip_mask;

	// each phase lasts prescale+1 cycles
	assign phase_end = busy_q && (pre_cnt == prescale_q);
	assign in_bits = phase < lab4d_pkg::shift_bit_phases;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			pre_cnt <= '0;
			phase <= '0;
		end else if (!busy_q) begin
			if (go_i) begin
				busy_q <= 1'b1;
				pre_cnt <= '0;
				phase <= '0;
			end
		end else if (phase_end) begin
			pre_cnt <= '0;
			if (phase == lab4d_pkg::shift_last_phase) begin
				busy_q <= 1'b0;
			end else begin
				phase <= phase + 1'b1;
			end
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// word and select held for the whole load
	always_ff @(posedge clk_i) begin
		if (!busy_q && go_i) begin
			shreg <= cmd_i.data;
			sel_q <= cmd_i.sel;
			prescale_q <= prescale_i;
		end else if (phase_end && in_bits && phase[0]) begin
			// next bit after the high phase
			shreg <= {shreg[lab4d_pkg::serial_width-2:0], 1'b0};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// line decode and chip gating
	//////////////////////////////////////////////////////////////////////

	assign sin_bit = busy_q && in_bits && shreg[lab4d_pkg::serial_width-1];
	assign sclk_bit = busy_q && in_bits && phase[0];
	assign pclk_bit = busy_q && (phase == lab4d_pkg::shift_pclk_phase);

	always_comb begin
		chip_mask = '0;
		if (sel_q >= lab4d_pkg::num_chips) begin
			chip_mask = '1;
		end else begin
			chip_mask[sel_q] = 1'b1;
		end
	end

	assign pins_o.sin = chip_mask & {lab4d_pkg::num_chips{sin_bit}};
	assign pins_o.sclk = chip_mask & {lab4d_pkg::num_chips{sclk_bit}};
	assign pins_o.pclk = chip_mask & {lab4d_pkg::num_chips{pclk_bit}};
	assign busy_o = busy_q;

endmodule

/* common/lab4d_pkg.sv */
package lab4d_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned num_chips = 12;
	localparam int unsigned serial_width = 24;
	localparam int unsigned wb_dat_width = 32;
	localparam int unsigned wb_adr_width = 7;

	//////////////////////////////////////////////////////////////////////
	// register word indices with byte address index * 4
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned reg_control = 0;
	localparam int unsigned reg_shift_prescale = 1;
	localparam int unsigned reg_ramp_delay = 3;
	localparam int unsigned reg_wclk_stop = 4;
	localparam int unsigned reg_serial = 6;

	// control word bit positions
	localparam int unsigned ctrl_runmode_bit = 1;
	localparam int unsigned ctrl_ramp_go_bit = 3;
	localparam int unsigned ctrl_ramp_busy_bit = 4;
	localparam int unsigned ctrl_regclr_lsb = 16;

	// serial word bit that is go on write and busy on read
	localparam int unsigned serial_go_bit = 31;

	//////////////////////////////////////////////////////////////////////
	// reset defaults
	//////////////////////////////////////////////////////////////////////

	localparam logic [7:0] shift_prescale_default = 8'd0;
	localparam logic [15:0] ramp_delay_default = 16'd0;
	localparam logic [15:0] wclk_stop_default = 16'd4096;

	// shifter sequence of 48 bit phases, a gap, PCLK and two idle phases
	localparam int unsigned shift_phase_width = 6;
	localparam int unsigned shift_bit_phases = 2 * serial_width;
	localparam int unsigned shift_pclk_phase = shift_bit_phases + 1;
	localparam int unsigned shift_last_phase = shift_bit_phases + 3;

	//////////////////////////////////////////////////////////////////////
	// structs
	//////////////////////////////////////////////////////////////////////

	// select 12..15 means all chips
	typedef struct packed {
		logic [3:0] sel;
		logic [serial_width-1:0] data;
	} serial_cmd_t;

	typedef struct packed {
		logic [15:0] stop_count;
		logic [15:0] delay;
	} ramp_cfg_t;

	typedef struct packed {
		logic [num_chips-1:0] sin;
		logic [num_chips-1:0] sclk;
		logic [num_chips-1:0] pclk;
	} lab4_serial_t;

endpackage
